// File: source/tilePkg.sv
package tilePkg;

	localparam int addrWidth = 48;	// physical address bits

	// status returned by memory and held as a level
	typedef enum logic [1:0]
	{
		memOkReady = 2'b00,
		memOkOk    = 2'b01,
		memOkHold  = 2'b10,
		memOkFault = 2'b11
	} memOkT;

	// operation code driven by a requester
	typedef enum logic [4:0]
	{
		memOpmReady  = 5'b00000,	// no request
		memOpmRdTile = 5'b01111,	// 16 bytes for the fetch tile
		memOpmRdLine = 5'b01011		// 16 bytes for the load tile
	} memOpmT;

	// one bus beat seen as instruction words or as data words
	typedef union packed
	{
		logic [7:0][15:0] hwords;
		logic [1:0][63:0] dwords;
	} busWordU;

	typedef struct packed
	{
		logic [addrWidth-1:0] addr;	// 16-byte block that may start on an odd 8-byte unit for fetch
		memOpmT               opm;
	} memReqT;

	typedef struct packed
	{
		busWordU data;
		memOkT   ok;
	} memRespT;

	// fetch window as seen by the core
	typedef struct packed
	{
		logic [addrWidth-1:0] pcVal;
		memOkT                ok;
		logic [1:0]           step;	// instruction length in 16-bit words
	} fetchOutT;

	typedef struct packed
	{
		logic [63:0] value;
		memOkT       ok;
	} loadOutT;

endpackage

// File: source/icTile.sv
`timescale 1ns/100ps

module icTile
(
	input  logic              clock,
	input  logic              arstN,
	input  logic [63:0]       pc,
	output tilePkg::fetchOutT fetchOut,
	output tilePkg::memReqT   busReq,
	input  tilePkg::memRespT  busResp
);

	import tilePkg::*;

	// opcode prefix decides how many words the instruction takes
	function automatic logic [1:0] stepOf(input logic [15:0] word);
		casez (word[15:10])
			6'b111111: return 2'd3;
			6'b111110: return 2'd2;
			6'b11110?: return 2'd2;
			default:   return 2'd1;
		endcase
	endfunction

	busWordU              blkData;	// cached fetch block
	logic [44:0]          blkAddr;	// block start in 8-byte units
	logic                 blkValid;

	logic [addrWidth-1:0] reqAddr;
	memOpmT               reqOpm;

	logic [44:0]          pcUnit;
	logic                 inLow;
	logic                 inHigh;
	logic [2:0]           wordIx;
	logic [9:0][15:0]     ext;	// block plus two zero words past its end
	logic [3:0]           ix0;
	logic [1:0]           step;
	logic                 tailMiss;
	logic                 hit;
	logic                 miss;
	logic                 pending;
	logic                 fill;
	logic                 faultNow;

	assign pcUnit = pc[addrWidth-1:3];
	assign inLow  = blkValid && (pcUnit == blkAddr);
	assign inHigh = blkValid && (pcUnit == blkAddr + 45'd1);
	assign wordIx = {inHigh, pc[2:1]};	// upper half when pc sits one unit above block start

	assign ext  = {32'h0, blkData.hwords};
	assign ix0  = {1'b0, wordIx};
	assign step = stepOf(ext[ix0]);

	// long opcode running off the block end needs a refetch
	assign tailMiss = ((wordIx == 3'd6) && (step == 2'd3)) ||
		((wordIx == 3'd7) && (step != 2'd1));

	assign hit  = (inLow || inHigh) && !tailMiss;
	assign miss = !hit;

	assign pending  = (reqOpm != memOpmReady);
	assign fill     = pending && (busResp.ok == memOkOk);
	assign faultNow = pending && (busResp.ok == memOkFault);

	always_comb
	begin
		fetchOut.pcVal = {ext[ix0 + 4'd2], ext[ix0 + 4'd1], ext[ix0]};
		fetchOut.step  = step;
		if (hit)
			fetchOut.ok = memOkOk;
		else if (faultNow)
			fetchOut.ok = memOkFault;	// passed through for the core to decide
		else
			fetchOut.ok = memOkHold;
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			reqOpm   <= memOpmReady;
			blkValid <= 1'b0;
		end
		else if (pending)
		begin
			if (fill || faultNow)
				reqOpm <= memOpmReady;	// drop the request the cycle after the answer
			if (fill)
				blkValid <= 1'b1;
		end
		else if (miss)
			reqOpm <= memOpmRdTile;
	end

	always_ff @(posedge clock)
	begin
		if (!pending && miss)
			reqAddr <= {pcUnit, 3'b000};
		if (fill)
		begin
			blkData <= busResp.data;
			blkAddr <= reqAddr[addrWidth-1:3];
		end
	end

	assign busReq.addr = reqAddr;
	assign busReq.opm  = reqOpm;

	aValidHit: assert property (@(posedge clock) disable iff (!arstN)
		(fetchOut.ok == memOkOk) |-> blkValid)
		else $error("fetch ok without a valid block");

	// request must not move while memory is still working on it
	aReqStable: assert property (@(posedge clock) disable iff (!arstN)
		(pending && busResp.ok == memOkHold) |=>
		(busReq.opm != memOpmReady) && $stable(busReq.addr))
		else $error("fetch request changed under hold");

endmodule

// File: source/dataTile.sv
`timescale 1ns/100ps

module dataTile
(
	input  logic                            clock,
	input  logic                            arstN,
	input  logic [tilePkg::addrWidth-1:0]   loadAddr,
	input  logic                            loadReq,
	output tilePkg::loadOutT                loadOut,
	output tilePkg::memReqT                 busReq,
	input  tilePkg::memRespT                busResp
);

	import tilePkg::*;

	busWordU              lineData;
	logic [43:0]          lineTag;	// address bits 47:4
	logic                 lineValid;

	logic [addrWidth-1:0] reqAddr;
	memOpmT               reqOpm;

	logic                 hit;
	logic                 miss;
	logic                 pending;
	logic                 fill;
	logic                 faultNow;

	assign hit      = loadReq && lineValid && (loadAddr[addrWidth-1:4] == lineTag);
	assign miss     = loadReq && !hit;
	assign pending  = (reqOpm != memOpmReady);
	assign fill     = pending && (busResp.ok == memOkOk);
	assign faultNow = pending && (busResp.ok == memOkFault);

	always_comb
	begin
		loadOut.value = lineData.dwords[loadAddr[3]];	// low or high dword of the line
		if (!loadReq)
			loadOut.ok = memOkReady;
		else if (hit)
			loadOut.ok = memOkOk;
		else if (faultNow)
			loadOut.ok = memOkFault;	// only in the answer cycle
		else
			loadOut.ok = memOkHold;
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			reqOpm    <= memOpmReady;
			lineValid <= 1'b0;
		end
		else if (pending)
		begin
			if (fill || faultNow)
				reqOpm <= memOpmReady;
			if (fill)
				lineValid <= 1'b1;	// a fault leaves it cleared
		end
		else if (miss)
		begin
			reqOpm    <= memOpmRdLine;
			lineValid <= 1'b0;	// old line is being replaced
		end
	end

	always_ff @(posedge clock)
	begin
		if (!pending && miss)
			reqAddr <= {loadAddr[addrWidth-1:4], 4'h0};
		if (fill)
		begin
			lineData <= busResp.data;
			lineTag  <= reqAddr[addrWidth-1:4];
		end
	end

	assign busReq.addr = reqAddr;
	assign busReq.opm  = reqOpm;

	aAligned: assert property (@(posedge clock) disable iff (!arstN)
		loadReq |-> (loadAddr[2:0] == 3'b000))
		else $error("misaligned load address");

endmodule

// File: source/memArbiter.sv
`timescale 1ns/100ps

module memArbiter
(
	input  logic             clock,
	input  logic             arstN,
	input  tilePkg::memReqT  icReq,
	input  tilePkg::memReqT  dataReq,
	output tilePkg::memRespT icResp,
	output tilePkg::memRespT dataResp,
	output tilePkg::memReqT  memReq,
	input  tilePkg::memRespT memResp
);

	import tilePkg::*;

	logic grantIc;
	logic grantData;
	logic lastData;	// data tile won the last round
	logic busy;
	logic icWants;
	logic dataWants;
	logic pickIc;
	logic pickData;
	logic curIc;
	logic curData;
	logic done;

	assign icWants   = (icReq.opm != memOpmReady);
	assign dataWants = (dataReq.opm != memOpmReady);

	// on a tie the tile that lost last time goes first
	assign pickIc   = icWants && (!dataWants || lastData);
	assign pickData = dataWants && !pickIc;

	assign busy    = grantIc || grantData;
	assign curIc   = busy ? grantIc : pickIc;
	assign curData = busy ? grantData : pickData;
	assign done    = (memResp.ok == memOkOk) || (memResp.ok == memOkFault);

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			grantIc   <= 1'b0;
			grantData <= 1'b0;
			lastData  <= 1'b0;
		end
		else
		begin
			grantIc   <= curIc && !done;	// released with the answer
			grantData <= curData && !done;
			if (!busy && (pickIc || pickData))
				lastData <= pickData;
		end
	end

	always_comb
	begin
		if (curIc)
			memReq = icReq;
		else if (curData)
			memReq = dataReq;
		else
			memReq = '{addr: '0, opm: memOpmReady};
	end

	// data fans out while status goes only to the granted tile
	assign icResp.data   = memResp.data;
	assign icResp.ok     = curIc ? memResp.ok : memOkHold;
	assign dataResp.data = memResp.data;
	assign dataResp.ok   = curData ? memResp.ok : memOkHold;

	aOneGrant: assert property (@(posedge clock) disable iff (!arstN)
		!(grantIc && grantData))
		else $error("both tiles granted");

	aGrantHeld: assert property (@(posedge clock) disable iff (!arstN)
		(busy && memResp.ok == memOkHold) |=> $stable({grantIc, grantData}))
		else $error("grant moved while memory holds");

endmodule

// File: source/fetchTop.sv
`timescale 1ns/100ps

module fetchTop
(
	input  logic                          clock,
	input  logic                          arstN,
	input  logic [63:0]                   pc,
	output tilePkg::fetchOutT             fetchOut,
	input  logic [tilePkg::addrWidth-1:0] loadAddr,
	input  logic                          loadReq,
	output tilePkg::loadOutT              loadOut,
	output tilePkg::memReqT               memReq,
	input  tilePkg::memRespT              memResp
);

	import tilePkg::*;

	memReqT  icReq;	// fetch tile to arbiter
	memReqT  dataReq;
	memRespT icResp;
	memRespT dataResp;

	icTile u_icTile
	(
		.clock    (clock),
		.arstN    (arstN),
		.pc       (pc),
		.fetchOut (fetchOut),
		.busReq   (icReq),
		.busResp  (icResp)
	);

	dataTile u_dataTile
	(
		.clock    (clock),
		.arstN    (arstN),
		.loadAddr (loadAddr),
		.loadReq  (loadReq),
		.loadOut  (loadOut),
		.busReq   (dataReq),
		.busResp  (dataResp)
	);

	// single memory port shared by both tiles
	memArbiter u_memArbiter
	(
		.clock    (clock),
		.arstN    (arstN),
		.icReq    (icReq),
		.dataReq  (dataReq),
		.icResp   (icResp),
		.dataResp (dataResp),
		.memReq   (memReq),
		.memResp  (memResp)
	);

endmodule

// File: tb/memModel.sv
`timescale 1ns/100ps

module memModel
(
	input  logic                          clock,
	input  logic                          arstN,
	input  logic [31:0]                   seed,
	input  logic [tilePkg::addrWidth-1:0] faultAddr,
	input  tilePkg::memReqT               memReq,
	output tilePkg::memRespT              memResp
);

	import tilePkg::*;

	logic [1:0] waitCnt;	// hold cycles already answered

	// 16-bit word stored at byte address a
	function automatic logic [15:0] wordAt(input logic [addrWidth-1:0] a, input logic [31:0] s);
		logic [31:0] h;
		h = a[31:0] ^ {a[47:32], a[47:32]};
		h = h * 32'h9e3779b1 + s;
		h = h ^ (h >> 13);
		h = h * 32'h85ebca6b;
		h = h ^ (h >> 16);
		if (a[4:1] == 4'he)
			h[15:10] = 6'b111111;	// three-word opcode
		else if (a[4:1] == 4'hf)
			h[15:10] = 6'b111100;	// two-word opcode
		return h[15:0];
	endfunction

	function automatic busWordU lineAt(input logic [addrWidth-1:0] base, input logic [31:0] s);
		busWordU w;
		for (int i = 0; i < 8; i++)
			w.hwords[i] = wordAt(base + 2 * i, s);
		return w;
	endfunction

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			waitCnt      <= 2'd0;
			memResp.ok   <= memOkReady;
			memResp.data <= '0;
		end
		else if (memResp.ok == memOkOk || memResp.ok == memOkFault)
		begin
			memResp.ok <= memOkReady;	// answer lasts one cycle
			waitCnt    <= 2'd0;
		end
		else if (memReq.opm == memOpmReady)
		begin
			memResp.ok <= memOkReady;
			waitCnt    <= 2'd0;
		end
		else if (waitCnt != 2'd3)
		begin
			memResp.ok <= memOkHold;
			waitCnt    <= waitCnt + 2'd1;
		end
		else
		begin
			memResp.data <= lineAt(memReq.addr, seed);
			memResp.ok   <= (memReq.addr == faultAddr) ? memOkFault : memOkOk;
		end
	end

endmodule

// File: tb/fetchTopTb.sv
`timescale 1ns/100ps

module fetchTopTb;

	import tilePkg::*;

	logic                 clock;
	logic                 arstN;
	logic [63:0]          pc;
	logic [addrWidth-1:0] loadAddr;
	logic                 loadReq;
	fetchOutT             fetchOut;
	loadOutT              loadOut;
	memReqT               memReq;
	memRespT              memResp;
	logic [31:0]          memSeed;	// contents of the memory model
	logic [addrWidth-1:0] faultAddr;

	integer seed;	// stimulus randomness
	int     errCount;
	int     checkCount;
	int     testCount;
	int     failedTests;
	int     testErrs;
	logic   busBusy;
	memReqT busHeld;

	fetchTop u_dut
	(
		.clock    (clock),
		.arstN    (arstN),
		.pc       (pc),
		.fetchOut (fetchOut),
		.loadAddr (loadAddr),
		.loadReq  (loadReq),
		.loadOut  (loadOut),
		.memReq   (memReq),
		.memResp  (memResp)
	);

	memModel u_mem
	(
		.clock     (clock),
		.arstN     (arstN),
		.seed      (memSeed),
		.faultAddr (faultAddr),
		.memReq    (memReq),
		.memResp   (memResp)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#20 clock = ~clock;
	end

	// expected memory word at byte address a
	function automatic logic [15:0] wordAt(input logic [addrWidth-1:0] a);
		logic [31:0] h;
		h = a[31:0] ^ {a[47:32], a[47:32]};
		h = h * 32'h9e3779b1 + memSeed;
		h = h ^ (h >> 13);
		h = h * 32'h85ebca6b;
		h = h ^ (h >> 16);
		if (a[4:1] == 4'he)
			h[15:10] = 6'b111111;
		else if (a[4:1] == 4'hf)
			h[15:10] = 6'b111100;
		return h[15:0];
	endfunction

	function automatic fetchOutT refFetch(input logic [63:0] p);
		fetchOutT    r;
		logic [15:0] w0;
		w0      = wordAt(p[47:0]);
		r.pcVal = {wordAt(p[47:0] + 4), wordAt(p[47:0] + 2), w0};
		r.ok    = memOkOk;
		if (w0[15:10] == 6'h3f)
			r.step = 2'd3;
		else if (w0[15:12] == 4'hf)
			r.step = 2'd2;	// 111110 and 11110x
		else
			r.step = 2'd1;
		return r;
	endfunction

	function automatic loadOutT refLoad(input logic [addrWidth-1:0] a);
		loadOutT r;
		r.value = {wordAt(a + 6), wordAt(a + 4), wordAt(a + 2), wordAt(a)};
		r.ok    = memOkOk;
		return r;
	endfunction

	task automatic flagMismatch(input string name, input logic [127:0] expVal,
		input logic [127:0] gotVal);
		$display("ERR %0t %s expected %0h got %0h", $time, name, expVal, gotVal);
		errCount++;
	endtask

	task automatic endRun();
		$display("tests %0d, failing tests %0d, checks %0d, errors %0d",
			testCount, failedTests, checkCount, errCount);
		if (errCount == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	endtask

	task automatic abortOnTimeout(input string what);
		$display("%0t: timed out after 64 cycles waiting for %s", $time, what);
		errCount++;
		endRun();
	endtask

	task automatic closeTest(input string name);
		testCount++;
		if (errCount != testErrs)
		begin
			failedTests++;
			$display("test %0d %s: FAIL with %0d errors", testCount, name, errCount - testErrs);
		end
		else
			$display("test %0d %s: ok", testCount, name);
		testErrs = errCount;
	endtask

	task automatic checkFetch(input fetchOutT exp);
		logic [63:0] mask;
		int          n;
		n = 1;
		@(negedge clock);
		while (fetchOut.ok == memOkHold && n < 64)
		begin
			@(negedge clock);
			n++;
		end
		mask = (64'd1 << (16 * exp.step)) - 64'd1;	// words the instruction uses
		if (fetchOut.ok == memOkHold)
			abortOnTimeout("fetch result");
		else
		begin
			checkCount++;
			if (fetchOut.ok != exp.ok)
				flagMismatch("fetchOut.ok", exp.ok, fetchOut.ok);
			else if (fetchOut.step != exp.step)
				flagMismatch("fetchOut.step", exp.step, fetchOut.step);
			else if ((fetchOut.pcVal & mask[47:0]) != (exp.pcVal & mask[47:0]))
				flagMismatch("fetchOut.pcVal", exp.pcVal & mask[47:0],
					fetchOut.pcVal & mask[47:0]);
		end
	endtask

	task automatic checkLoad(input loadOutT exp, output int waited);
		int n;
		n = 1;
		@(negedge clock);
		while (loadOut.ok == memOkHold && n < 64)
		begin
			@(negedge clock);
			n++;
		end
		waited = n;
		if (loadOut.ok == memOkHold)
			abortOnTimeout("load result");
		else
		begin
			checkCount++;
			if (loadOut.ok != exp.ok)
				flagMismatch("loadOut.ok", exp.ok, loadOut.ok);
			else if (exp.ok == memOkOk && loadOut.value != exp.value)
				flagMismatch("loadOut.value", exp.value, loadOut.value);
		end
	endtask

	task automatic checkReq(input memReqT exp);
		int n;
		n = 1;
		@(negedge clock);
		while (memReq.opm == memOpmReady && n < 64)
		begin
			@(negedge clock);
			n++;
		end
		if (memReq.opm == memOpmReady)
			abortOnTimeout("a memory request");
		else
		begin
			checkCount++;
			if (memReq.opm != exp.opm)
				flagMismatch("memReq.opm", exp.opm, memReq.opm);
			else if (memReq.addr != exp.addr)
				flagMismatch("memReq.addr", exp.addr, memReq.addr);
		end
	endtask

	task automatic fetchAndCheck(input logic [63:0] p);
		fetchOutT exp;
		exp = refFetch(p);
		@(posedge clock);
		pc <= p;
		checkFetch(exp);
	endtask

	// one transfer at a time on the memory bus
	always @(negedge clock)
	begin
		if (!arstN)
			busBusy = 1'b0;
		else if (memResp.ok == memOkOk || memResp.ok == memOkFault)
			busBusy = 1'b0;
		else if (memReq.opm != memOpmReady)
		begin
			if (busBusy && memReq != busHeld)
				flagMismatch("memReq", busHeld, memReq);
			busBusy = 1'b1;
			busHeld = memReq;
		end
	end

	initial
	begin
		logic [63:0]          p;
		logic [addrWidth-1:0] a;
		loadOutT              lexp;
		fetchOutT             fexp;
		int                   waited;
		seed        = 32'hd9e9;
		memSeed     = 32'hd9e9;
		faultAddr   = '1;	// all ones is never a request address
		errCount    = 0;
		checkCount  = 0;
		testCount   = 0;
		failedTests = 0;
		testErrs    = 0;
		arstN       = 1'b0;
		pc          = '0;
		loadAddr    = '0;
		loadReq     = 1'b0;

		// idle bus and hold status while in reset
		for (int i = 0; i < 10; i++)
		begin
			@(posedge clock);
			pc <= {32'h0, $random(seed)} & ~64'h1;
			@(negedge clock);
			checkCount++;
			if (memReq.opm != memOpmReady)
				flagMismatch("memReq.opm", memOpmReady, memReq.opm);
			if (fetchOut.ok != memOkHold)
				flagMismatch("fetchOut.ok", memOkHold, fetchOut.ok);
		end
		p = 64'h0000_0000_4a5c_3b38;	// odd 8-byte unit
		@(posedge clock);
		arstN <= 1'b1;
		pc    <= p;
		checkReq('{addr: {p[47:3], 3'b000}, opm: memOpmRdTile});
		checkFetch(refFetch(p));
		closeTest("reset and first miss");

		for (int i = 0; i < 48; i++)
		begin
			fexp = refFetch(p);
			fetchAndCheck(p);
			p = p + 2 * fexp.step;
		end
		closeTest("sequential fetch");

		fetchAndCheck(64'h0000_0000_7770_0010);
		@(posedge clock);
		pc <= 64'h0000_0000_7770_001c;	// index 6 with a three-word opcode
		checkReq('{addr: 48'h0000_7770_0018, opm: memOpmRdTile});
		checkFetch(refFetch(64'h0000_0000_7770_001c));
		fetchAndCheck(64'h0000_0000_3310_0010);
		@(posedge clock);
		pc <= 64'h0000_0000_3310_001e;	// index 7 with a two-word opcode
		checkReq('{addr: 48'h0000_3310_0018, opm: memOpmRdTile});
		checkFetch(refFetch(64'h0000_0000_3310_001e));
		closeTest("long opcode refetch");

		for (int i = 0; i < 8; i++)
		begin
			a[47:32] = $random(seed);
			a[31:3]  = $random(seed);
			a[2:0]   = 3'b000;
			@(posedge clock);
			loadReq  <= 1'b1;
			loadAddr <= a;
			checkLoad(refLoad(a), waited);
			@(posedge clock);
			loadAddr <= a ^ 48'h8;	// other half of the same line
			checkLoad(refLoad(a ^ 48'h8), waited);
			if (waited != 1)
			begin
				$display("%0t: load in a filled line took %0d cycles", $time, waited);
				errCount++;
			end
		end
		@(posedge clock);
		loadReq <= 1'b0;
		closeTest("aligned loads");

		for (int i = 0; i < 4; i++)
		begin
			p        = '0;
			p[47:32] = $random(seed);
			p[31:1]  = $random(seed);
			a[47:32] = $random(seed);
			a[31:3]  = $random(seed);
			a[2:0]   = 3'b000;
			@(posedge clock);
			pc       <= p;
			loadAddr <= a;
			loadReq  <= 1'b1;
			checkFetch(refFetch(p));
			checkLoad(refLoad(a), waited);
			@(posedge clock);
			loadReq <= 1'b0;
		end
		closeTest("concurrent misses");

		a = 48'h0000_0bad_0040;
		@(posedge clock);
		faultAddr <= a;
		loadAddr  <= a;
		loadReq   <= 1'b1;
		lexp.value = '0;
		lexp.ok    = memOkFault;
		checkLoad(lexp, waited);
		@(posedge clock);
		faultAddr <= '1;
		checkReq('{addr: a, opm: memOpmRdLine});	// retry goes back to memory
		checkLoad(refLoad(a), waited);
		@(posedge clock);
		loadReq <= 1'b0;
		closeTest("load fault and retry");

		endRun();
	end

endmodule

// File: fetchTile.f
source/tilePkg.sv
source/icTile.sv
source/dataTile.sv
source/memArbiter.sv
source/fetchTop.sv
tb/memModel.sv
tb/fetchTopTb.sv

// File: Bender.yml
package:
  name: fetchTile

sources:
  - source/tilePkg.sv
  - source/icTile.sv
  - source/dataTile.sv
  - source/memArbiter.sv
  - source/fetchTop.sv
  - target: simulation
    files:
      - tb/memModel.sv
      - tb/fetchTopTb.sv
